//--- Bender.yml
package:
  name: layer_norm

sources:
  - include_dirs:
      - .
    files:
      - ln_fixed_pkg.sv
      - ln_vector_pkg.sv
      - ln_input_stage.sv
      - ln_stats.sv
      - ln_std_dev_pipe.sv
      - ln_output_stage.sv
      - layer_norm_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - layer_norm_checker.sv
      - ln_monitor.sv
      - tb_layer_norm.sv

//--- layer_norm_checker.sv
`timescale 1ns/1ps
`default_nettype none

module layer_norm_checker (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic data_in_valid,
    input  wire logic data_out_valid
);
    `include "ln_settings.svh"

    int unsigned fail_count = 0;
    logic        rst_seen;

    // High one cycle after an edge that saw reset, once the valid flops are cleared
    always_ff @(posedge clk)
    begin
        rst_seen <= !rst_n;
    end

    quiet_in_reset: assert property (@(posedge clk) (!rst_n && rst_seen) |-> !data_out_valid)
    else
    begin
        $error("data_out_valid is high while rst_n is low");
        fail_count++;
    end

    fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
        data_in_valid |-> ##(`LN_LATENCY) data_out_valid)
    else
    begin
        $error("data_out_valid missing %0d cycles after data_in_valid", `LN_LATENCY);
        fail_count++;
    end

    no_stray_output: assert property (@(posedge clk) disable iff (!rst_n)
        data_out_valid |-> $past(data_in_valid, `LN_LATENCY))
    else
    begin
        $error("data_out_valid without an input %0d cycles earlier", `LN_LATENCY);
        fail_count++;
    end

endmodule

`default_nettype wire

//--- layer_norm_top.sv
`timescale 1ns/1ps
`default_nettype none

module layer_norm_top (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire ln_vector_pkg::elem_vec_t data_in,
    input  wire logic                     data_in_valid,
    input  wire ln_vector_pkg::elem_vec_t gamma,
    input  wire ln_vector_pkg::elem_vec_t beta,
    output ln_vector_pkg::elem_vec_t      data_out,
    output logic                          data_out_valid
);
    import ln_fixed_pkg::*;
    import ln_vector_pkg::*;

    // Input side to statistics
    elem_vec_t data_q;
    elem_vec_t gamma_q;
    elem_vec_t beta_q;
    sum_t      mean;
    logic      mean_valid;

    // Statistics to square root
    diff_vec_t diff;
    var_t      variance;
    elem_vec_t gamma_s;
    elem_vec_t beta_s;
    logic      stats_valid;

    // Square root to output side
    std_t      std_dev;
    diff_vec_t diff_d;
    elem_vec_t gamma_d;
    elem_vec_t beta_d;
    logic      std_valid;

    ln_input_stage i_ln_input_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_in       (data_in),
        .data_in_valid (data_in_valid),
        .gamma         (gamma),
        .beta          (beta),
        .data_q        (data_q),
        .gamma_q       (gamma_q),
        .beta_q        (beta_q),
        .mean          (mean),
        .mean_valid    (mean_valid)
    );

    ln_stats i_ln_stats (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_q      (data_q),
        .gamma_q     (gamma_q),
        .beta_q      (beta_q),
        .mean        (mean),
        .mean_valid  (mean_valid),
        .diff        (diff),
        .variance    (variance),
        .gamma_s     (gamma_s),
        .beta_s      (beta_s),
        .stats_valid (stats_valid)
    );

    ln_std_dev_pipe i_ln_std_dev_pipe (
        .clk         (clk),
        .rst_n       (rst_n),
        .diff        (diff),
        .variance    (variance),
        .gamma_s     (gamma_s),
        .beta_s      (beta_s),
        .stats_valid (stats_valid),
        .std_dev     (std_dev),
        .diff_d      (diff_d),
        .gamma_d     (gamma_d),
        .beta_d      (beta_d),
        .std_valid   (std_valid)
    );

    ln_output_stage i_ln_output_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .std_dev        (std_dev),
        .diff_d         (diff_d),
        .gamma_d        (gamma_d),
        .beta_d         (beta_d),
        .std_valid      (std_valid),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

endmodule

`default_nettype wire

//--- ln_fixed_pkg.sv
`default_nettype none

`include "ln_settings.svh"

package ln_fixed_pkg;

    // Signed Q4.4 element
    typedef logic signed [`LN_WIDTH-1:0] elem_t;

    // Lane minus mean, one extra bit of range
    typedef logic signed [`LN_WIDTH:0] diff_t;

    // Sum over all lanes
    typedef logic signed [`LN_WIDTH+`LN_LANES_LOG2-1:0] sum_t;

    // Squared difference, 8 fractional bits
    typedef logic [2*(`LN_WIDTH+1)-1:0] sq_t;

    // Mean of the squares, same scaling as sq_t
    typedef logic [2*(`LN_WIDTH+1)-1:0] var_t;

    // Square root of the variance, 4 fractional bits
    typedef logic [`LN_SQRT_STAGES-1:0] std_t;

endpackage

`default_nettype wire

//--- ln_input_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ln_input_stage (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire ln_vector_pkg::elem_vec_t data_in,
    input  wire logic                     data_in_valid,
    input  wire ln_vector_pkg::elem_vec_t gamma,
    input  wire ln_vector_pkg::elem_vec_t beta,
    output ln_vector_pkg::elem_vec_t      data_q,
    output ln_vector_pkg::elem_vec_t      gamma_q,
    output ln_vector_pkg::elem_vec_t      beta_q,
    output ln_fixed_pkg::sum_t            mean,
    output logic                          mean_valid
);
    import ln_fixed_pkg::*;
    import ln_vector_pkg::*;

    `include "ln_settings.svh"

    elem_vec_t data_r;
    elem_vec_t gamma_r;
    elem_vec_t beta_r;
    logic      valid_r;
    sum_t      lane_sum;

    always_comb
    begin
        lane_sum = '0;
        for (int i = 0; i < `LN_LANES; i++)
        begin
            lane_sum = lane_sum + sum_t'(data_r[i]);
        end
    end

    always_ff @(posedge clk)
    begin
        data_r  <= data_in;
        gamma_r <= gamma;
        beta_r  <= beta;
        // Arithmetic shift floors the mean for negative sums too
        mean    <= lane_sum >>> `LN_LANES_LOG2;
        data_q  <= data_r;
        gamma_q <= gamma_r;
        beta_q  <= beta_r;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_r    <= 1'b0;
            mean_valid <= 1'b0;
        end
        else
        begin
            valid_r    <= data_in_valid;
            mean_valid <= valid_r;
        end
    end

endmodule

`default_nettype wire

//--- ln_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module ln_monitor (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire ln_vector_pkg::elem_vec_t data_out,
    input  wire logic                     data_out_valid,
    input  wire ln_vector_pkg::elem_vec_t exp_data,
    input  wire logic                     exp_push,
    output int                            n_pass,
    output int                            n_fail,
    output logic                          timed_out
);
    import ln_vector_pkg::*;

    `include "ln_settings.svh"

    // Longest wait for a pending output, in cycles
    localparam int TIMEOUT = 40;

    elem_vec_t exp_q   [$];
    int        stamp_q [$];

    initial
    begin
        int        cycle;
        int        test_id;
        int        lat;
        int        errs;
        elem_vec_t want;

        cycle     = 0;
        test_id   = 0;
        n_pass    = 0;
        n_fail    = 0;
        timed_out = 1'b0;
        while (!timed_out)
        begin
            @(posedge clk);
            cycle++;
            if (rst_n === 1'b1)
            begin
                // Each expected vector is stamped with the cycle its input was sampled
                if (exp_push)
                begin
                    exp_q.push_back(exp_data);
                    stamp_q.push_back(cycle);
                end
                if (data_out_valid === 1'b1)
                begin
                    if (exp_q.size() == 0)
                    begin
                        $display("Output at %0t ns with no input pending", $time);
                        n_fail++;
                    end
                    else
                    begin
                        want = exp_q.pop_front();
                        lat  = cycle - stamp_q.pop_front();
                        errs = 0;
                        for (int i = 0; i < `LN_LANES; i++)
                        begin
                            if (data_out[i] !== want[i])
                            begin
                                $display("** Error at %0t ns: test %0d lane %0d got %0d, expected %0d",
                                         $time, test_id, i, data_out[i], want[i]);
                                errs++;
                            end
                        end
                        if (lat != `LN_LATENCY)
                        begin
                            $display("Test %0d came out %0d cycles after its input, not %0d",
                                     test_id, lat, `LN_LATENCY);
                            errs++;
                        end
                        if (errs == 0)
                        begin
                            n_pass++;
                            $display("Test %0d ok", test_id);
                        end
                        else
                        begin
                            n_fail++;
                            $display("Test %0d mismatch", test_id);
                        end
                        test_id++;
                    end
                end
                else if (exp_q.size() != 0 && cycle - stamp_q[0] > TIMEOUT)
                begin
                    $display("Test %0d gave no output within %0d cycles", test_id, TIMEOUT);
                    timed_out = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- ln_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ln_output_stage (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire ln_fixed_pkg::std_t       std_dev,
    input  wire ln_vector_pkg::diff_vec_t diff_d,
    input  wire ln_vector_pkg::elem_vec_t gamma_d,
    input  wire ln_vector_pkg::elem_vec_t beta_d,
    input  wire logic                     std_valid,
    output ln_vector_pkg::elem_vec_t      data_out,
    output logic                          data_out_valid
);
    import ln_fixed_pkg::*;
    import ln_vector_pkg::*;

    `include "ln_settings.svh"

    // Difference moved up by the fractional bits of the result
    localparam int NUM_W  = $bits(diff_t) + `LN_FRAC;
    // Product with gamma plus one bit for the beta add
    localparam int PROD_W = NUM_W + `LN_WIDTH + 1;

    localparam logic signed [PROD_W-1:0] SAT_MAX = 2 ** (`LN_WIDTH - 1) - 1;
    localparam logic signed [PROD_W-1:0] SAT_MIN = -(2 ** (`LN_WIDTH - 1));

    logic signed [NUM_W-1:0]  norm_num [`LN_LANES];
    logic signed [NUM_W-1:0]  norm     [`LN_LANES];
    logic signed [NUM_W-1:0]  norm_r   [`LN_LANES];
    logic signed [PROD_W-1:0] res      [`LN_LANES];
    elem_vec_t                gamma_r;
    elem_vec_t                beta_r;
    logic                     valid_r;

    always_comb
    begin
        for (int i = 0; i < `LN_LANES; i++)
        begin
            norm_num[i] = {diff_d[i], {`LN_FRAC{1'b0}}};
            // Zero spread means every lane sits on the mean
            if (std_dev == '0)
            begin
                norm[i] = '0;
            end
            else
            begin
                norm[i] = norm_num[i] / $signed({1'b0, std_dev});
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < `LN_LANES; i++)
        begin
            res[i] = norm_r[i] * gamma_r[i];
            res[i] = (res[i] >>> `LN_FRAC) + beta_r[i];
        end
    end

    always_ff @(posedge clk)
    begin
        norm_r  <= norm;
        gamma_r <= gamma_d;
        beta_r  <= beta_d;

        for (int i = 0; i < `LN_LANES; i++)
        begin
            if (res[i] > SAT_MAX)
                data_out[i] <= elem_t'(SAT_MAX);
            else if (res[i] < SAT_MIN)
                data_out[i] <= elem_t'(SAT_MIN);
            else
                data_out[i] <= elem_t'(res[i]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_r        <= 1'b0;
            data_out_valid <= 1'b0;
        end
        else
        begin
            valid_r        <= std_valid;
            data_out_valid <= valid_r;
        end
    end

endmodule

`default_nettype wire

//--- ln_settings.svh
`ifndef LN_SETTINGS_SVH
`define LN_SETTINGS_SVH

// Vector shape
`define LN_LANES        8
`define LN_LANES_LOG2   3

// Q4.4 element format
`define LN_WIDTH        8
`define LN_FRAC         4

// One square-root stage per result bit
`define LN_SQRT_STAGES  9

// Input strobe to output strobe, in cycles
`define LN_LATENCY      16

`endif

//--- ln_stats.sv
`timescale 1ns/1ps
`default_nettype none

module ln_stats (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire ln_vector_pkg::elem_vec_t data_q,
    input  wire ln_vector_pkg::elem_vec_t gamma_q,
    input  wire ln_vector_pkg::elem_vec_t beta_q,
    input  wire ln_fixed_pkg::sum_t      mean,
    input  wire logic                     mean_valid,
    output ln_vector_pkg::diff_vec_t      diff,
    output ln_fixed_pkg::var_t            variance,
    output ln_vector_pkg::elem_vec_t      gamma_s,
    output ln_vector_pkg::elem_vec_t      beta_s,
    output logic                          stats_valid
);
    import ln_fixed_pkg::*;
    import ln_vector_pkg::*;

    `include "ln_settings.svh"

    // Room for the sum of all squares before the divide by the lane count
    localparam int SQ_SUM_W = $bits(sq_t) + `LN_LANES_LOG2;

    diff_vec_t             diff_a;
    diff_vec_t             diff_b;
    elem_vec_t             gamma_a;
    elem_vec_t             gamma_b;
    elem_vec_t             beta_a;
    elem_vec_t             beta_b;
    sq_t                   sq_b [`LN_LANES];
    logic [SQ_SUM_W-1:0]   sq_sum;
    logic                  valid_a;
    logic                  valid_b;

    always_comb
    begin
        sq_sum = '0;
        for (int i = 0; i < `LN_LANES; i++)
        begin
            sq_sum = sq_sum + SQ_SUM_W'(sq_b[i]);
        end
    end

    always_ff @(posedge clk)
    begin
        // Stage 1: difference from the mean
        for (int i = 0; i < `LN_LANES; i++)
        begin
            diff_a[i] <= diff_t'(sum_t'(data_q[i]) - mean);
        end
        gamma_a <= gamma_q;
        beta_a  <= beta_q;

        // Stage 2: square each difference
        for (int i = 0; i < `LN_LANES; i++)
        begin
            sq_b[i] <= diff_a[i] * diff_a[i];
        end
        diff_b  <= diff_a;
        gamma_b <= gamma_a;
        beta_b  <= beta_a;

        // Stage 3: mean of the squares
        variance <= var_t'(sq_sum >> `LN_LANES_LOG2);
        diff     <= diff_b;
        gamma_s  <= gamma_b;
        beta_s   <= beta_b;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_a     <= 1'b0;
            valid_b     <= 1'b0;
            stats_valid <= 1'b0;
        end
        else
        begin
            valid_a     <= mean_valid;
            valid_b     <= valid_a;
            stats_valid <= valid_b;
        end
    end

endmodule

`default_nettype wire

//--- ln_std_dev_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module ln_std_dev_pipe (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire ln_vector_pkg::diff_vec_t diff,
    input  wire ln_fixed_pkg::var_t       variance,
    input  wire ln_vector_pkg::elem_vec_t gamma_s,
    input  wire ln_vector_pkg::elem_vec_t beta_s,
    input  wire logic                     stats_valid,
    output ln_fixed_pkg::std_t            std_dev,
    output ln_vector_pkg::diff_vec_t      diff_d,
    output ln_vector_pkg::elem_vec_t      gamma_d,
    output ln_vector_pkg::elem_vec_t      beta_d,
    output logic                          std_valid
);
    import ln_fixed_pkg::*;
    import ln_vector_pkg::*;

    `include "ln_settings.svh"

    localparam int STAGES = `LN_SQRT_STAGES;
    // Two spare bits so the trial value never wraps
    localparam int REM_W  = $bits(var_t) + 2;

    // Inputs seen by each stage
    logic [REM_W-1:0] rem_in  [STAGES];
    std_t             root_in [STAGES];
    logic [REM_W-1:0] step    [STAGES];

    // Stage registers
    logic [REM_W-1:0] rem_q   [STAGES];
    std_t             root_q  [STAGES];
    diff_vec_t        diff_q  [STAGES];
    elem_vec_t        gamma_q [STAGES];
    elem_vec_t        beta_q  [STAGES];
    logic [STAGES-1:0] valid_q;

    always_comb
    begin
        rem_in[0]  = REM_W'(variance);
        root_in[0] = '0;
        for (int s = 1; s < STAGES; s++)
        begin
            rem_in[s]  = rem_q[s-1];
            root_in[s] = root_q[s-1];
        end

        // Stage s tries bit b = STAGES-1-s
        // (root + 2^b)^2 - root^2 = root * 2^(b+1) + 2^(2b)
        for (int s = 0; s < STAGES; s++)
        begin
            step[s] = (REM_W'(root_in[s]) << (STAGES - s))
                    + (REM_W'(1) << (2 * (STAGES - 1 - s)));
        end
    end

    always_ff @(posedge clk)
    begin
        for (int s = 0; s < STAGES; s++)
        begin
            if (rem_in[s] >= step[s])
            begin
                rem_q[s]  <= rem_in[s] - step[s];
                root_q[s] <= root_in[s] | (std_t'(1) << (STAGES - 1 - s));
            end
            else
            begin
                // Bit stays clear, remainder is kept
                rem_q[s]  <= rem_in[s];
                root_q[s] <= root_in[s];
            end
        end

        // Side-band moves in step with the root
        diff_q[0]  <= diff;
        gamma_q[0] <= gamma_s;
        beta_q[0]  <= beta_s;
        for (int s = 1; s < STAGES; s++)
        begin
            diff_q[s]  <= diff_q[s-1];
            gamma_q[s] <= gamma_q[s-1];
            beta_q[s]  <= beta_q[s-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_q <= '0;
        end
        else
        begin
            valid_q <= {valid_q[STAGES-2:0], stats_valid};
        end
    end

    assign std_dev   = root_q[STAGES-1];
    assign diff_d    = diff_q[STAGES-1];
    assign gamma_d   = gamma_q[STAGES-1];
    assign beta_d    = beta_q[STAGES-1];
    assign std_valid = valid_q[STAGES-1];

endmodule

`default_nettype wire

//--- ln_vector_pkg.sv
`default_nettype none

`include "ln_settings.svh"

package ln_vector_pkg;

    // Lane i sits at index i, lane 0 in the low bits
    typedef ln_fixed_pkg::elem_t [`LN_LANES-1:0] elem_vec_t;

    // Differences from the mean, one per lane
    typedef ln_fixed_pkg::diff_t [`LN_LANES-1:0] diff_vec_t;

endpackage

`default_nettype wire

//--- sources.f
+incdir+.
ln_fixed_pkg.sv
ln_vector_pkg.sv
ln_input_stage.sv
ln_stats.sv
ln_std_dev_pipe.sv
ln_output_stage.sv
layer_norm_top.sv
layer_norm_checker.sv
ln_monitor.sv
tb_layer_norm.sv

//--- tb_layer_norm.sv
`timescale 1ns/1ps
`default_nettype none

module tb_layer_norm;
    import ln_vector_pkg::*;

    `include "ln_settings.svh"

    localparam int NUM_TESTS     = 12;
    // Entries after this one follow each other with no idle cycle
    localparam int BURST_START   = 4;
    localparam int IDLE_GAP      = 3;
    localparam int DRAIN_TIMEOUT = 100;

    logic      clk;
    logic      rst_n;
    elem_vec_t data_in;
    logic      data_in_valid;
    elem_vec_t gamma;
    elem_vec_t beta;
    elem_vec_t data_out;
    logic      data_out_valid;
    elem_vec_t exp_data;
    logic      exp_push;
    int        n_pass;
    int        n_fail;
    logic      timed_out;
    logic [15:0] lfsr;

    // Stimulus table
    elem_vec_t tab_data  [NUM_TESTS];
    elem_vec_t tab_gamma [NUM_TESTS];
    elem_vec_t tab_beta  [NUM_TESTS];
    elem_vec_t tab_exp   [NUM_TESTS];
    bit        tab_b2b   [NUM_TESTS];

    layer_norm_top i_layer_norm_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .gamma          (gamma),
        .beta           (beta),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

    ln_monitor i_ln_monitor (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .exp_data       (exp_data),
        .exp_push       (exp_push),
        .n_pass         (n_pass),
        .n_fail         (n_fail),
        .timed_out      (timed_out)
    );

    bind layer_norm_top layer_norm_checker i_layer_norm_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_in_valid  (data_in_valid),
        .data_out_valid (data_out_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [`LN_WIDTH-1:0] v);
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            v    = {v[`LN_WIDTH-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Mean, variance, floor square root, divide, scale, offset, saturate
    function automatic elem_vec_t ref_model(input elem_vec_t d, input elem_vec_t g,
                                            input elem_vec_t b);
        int        sum;
        int        mean;
        int        sq;
        int        var_v;
        int        sd;
        int        norm;
        int        res;
        int        diff [`LN_LANES];
        elem_vec_t out;

        sum = 0;
        for (int i = 0; i < `LN_LANES; i++)
            sum += int'(d[i]);
        mean = sum >>> `LN_LANES_LOG2;
        sq = 0;
        for (int i = 0; i < `LN_LANES; i++)
        begin
            diff[i] = int'(d[i]) - mean;
            sq += diff[i] * diff[i];
        end
        var_v = sq >>> `LN_LANES_LOG2;
        sd = 0;
        while ((sd + 1) * (sd + 1) <= var_v)
            sd++;
        for (int i = 0; i < `LN_LANES; i++)
        begin
            norm = (sd == 0) ? 0 : (diff[i] * (1 << `LN_FRAC)) / sd;
            res  = ((norm * int'(g[i])) >>> `LN_FRAC) + int'(b[i]);
            if (res > 127)
                res = 127;
            else if (res < -128)
                res = -128;
            out[i] = res[`LN_WIDTH-1:0];
        end
        return out;
    endfunction

    task automatic build_table();
        logic [`LN_WIDTH-1:0] v;

        // All lanes equal, so the output is beta
        tab_data[0]  = {8{8'h25}};
        tab_gamma[0] = {8{8'h10}};
        tab_beta[0]  = {8'hF0, 8'h20, 8'h00, 8'h7F, 8'h80, 8'h11, 8'hEE, 8'h05};
        // Two outliers with a large gamma push lanes 0 and 7 into saturation
        tab_data[1]  = {8'h7F, 48'h0, 8'h80};
        tab_gamma[1] = {8{8'h7F}};
        tab_beta[1]  = '0;
        tab_b2b[0]   = 1'b0;
        tab_b2b[1]   = 1'b0;
        for (int t = 2; t < NUM_TESTS; t++)
        begin
            for (int i = 0; i < `LN_LANES; i++)
            begin
                take_bits(`LN_WIDTH, v);
                tab_data[t][i] = v;
                take_bits(`LN_WIDTH, v);
                tab_gamma[t][i] = v;
                take_bits(`LN_WIDTH, v);
                tab_beta[t][i] = v;
            end
            tab_b2b[t] = (t > BURST_START);
        end
        for (int t = 0; t < NUM_TESTS; t++)
            tab_exp[t] = ref_model(tab_data[t], tab_gamma[t], tab_beta[t]);
    endtask

    initial
    begin
        int wait_cycles;
        int asserts;

        rst_n         = 1'b0;
        data_in       = '0;
        data_in_valid = 1'b0;
        gamma         = '0;
        beta          = '0;
        exp_data      = '0;
        exp_push      = 1'b0;
        lfsr          = 16'd36;
        build_table();

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            if (!tab_b2b[t])
            begin
                @(posedge clk);
                data_in_valid <= 1'b0;
                exp_push      <= 1'b0;
                repeat (IDLE_GAP) @(posedge clk);
            end
            @(posedge clk);
            data_in       <= tab_data[t];
            gamma         <= tab_gamma[t];
            beta          <= tab_beta[t];
            data_in_valid <= 1'b1;
            exp_data      <= tab_exp[t];
            exp_push      <= 1'b1;
        end
        @(posedge clk);
        data_in_valid <= 1'b0;
        exp_push      <= 1'b0;

        wait_cycles = 0;
        while (n_pass + n_fail < NUM_TESTS && !timed_out && wait_cycles < DRAIN_TIMEOUT)
        begin
            @(posedge clk);
            wait_cycles++;
        end
        if (wait_cycles >= DRAIN_TIMEOUT)
            $display("Gave up waiting for the last outputs after %0d cycles", DRAIN_TIMEOUT);

        asserts = i_layer_norm_top.i_layer_norm_checker.fail_count;
        $display("Checked %0d of %0d, passed %0d, failed %0d, assertion failures %0d",
                 n_pass + n_fail, NUM_TESTS, n_pass, n_fail, asserts);
        if (n_pass == NUM_TESTS && n_fail == 0 && asserts == 0 && !timed_out)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
